// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = uart_rx_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/oversample_tick_gen.sv ====
`timescale 1ns/1ns

// Divides Clk down to the oversampling tick
// The divider only runs while the receiver is busy, so each frame starts from a fresh count
module oversample_tick_gen #(
    parameter int CLKS_PER_TICK = 4
) (
    input  logic Clk,
    input  logic Rst,
    input  logic run,   // High while a frame is in progress
    output logic tick   // One Clk wide, once every CLKS_PER_TICK cycles
);

    localparam int CW = $clog2(CLKS_PER_TICK);

    logic [CW-1:0] div_cnt;  // Clk cycles since the last tick

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (!run) begin
            div_cnt <= '0;  // Held and restarted while the receiver is idle
            tick    <= 1'b0;
        end else if (div_cnt == CW'(CLKS_PER_TICK - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;  // Lands CLKS_PER_TICK cycles after run rises
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

// ==== design/rx_credit_if.sv ====
`timescale 1ns/1ns

// Word and credit link between the frame receiver and the receive FIFO
interface rx_credit_if import rx_data_pkg::*;;

    logic                push;         // One cycle per delivered word
    rx_word_t            word;         // Valid while push is high
    logic                credit_ret;   // One cycle per word the FIFO frees
    logic [CREDIT_W-1:0] credit_init;  // Number of credits after reset, held constant

    // Frame receiver side
    modport sender (
        output push,
        output word,
        input  credit_ret,
        input  credit_init
    );

    // FIFO side
    modport receiver (
        input  push,
        input  word,
        output credit_ret,
        output credit_init
    );

endinterface

// ==== design/rx_data_pkg.sv ====
package rx_data_pkg;

    // Width of the data field in every received word
    localparam int MAX_DATA_BITS = 8;

    // Width of the credit count passed from the FIFO to the receiver
    // Wide enough for any practical FIFO depth
    localparam int CREDIT_W = 16;

    // Error flags that travel with each word
    typedef struct packed {
        logic overrun;     // A word was dropped before this one for lack of room
        logic break_err;   // Every sampled bit of the frame was low
        logic frame_err;   // A stop bit was sampled low
        logic parity_err;  // Parity bit disagrees with the data
    } rx_err_t;

    // One received word as the host reads it
    // Short frames are right-aligned with zeros above
    typedef struct packed {
        rx_err_t                  err;   // Flags in the top four bits
        logic [MAX_DATA_BITS-1:0] data;  // Received data
    } rx_word_t;

endpackage

// ==== design/rx_fifo.sv ====
`timescale 1ns/1ns

// Receive word FIFO in show-ahead form
// The oldest word sits on rd_word whenever rd_valid is high
// Every pop hands one credit back to the receiver in the same cycle
module rx_fifo import rx_data_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic         Clk,
    input  logic         Rst,
    rx_credit_if.receiver rx,
    input  logic         rd_en,     // Host takes the word on rd_word
    output logic         rd_valid,  // FIFO holds at least one word
    output rx_word_t     rd_word    // Oldest word
);

    localparam int AW = $clog2(FIFO_DEPTH);

    rx_word_t mem [FIFO_DEPTH];  // Word storage

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;  // Occupancy, one bit wider to reach FIFO_DEPTH
    logic          pop;

    assign pop = rd_en && rd_valid;

    always_ff @(posedge Clk) begin
        if (rx.push) begin
            mem[wr_ptr] <= rx.word;  // Credits guarantee a free slot here
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (rx.push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, so it wraps on its own
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({rx.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rd_valid = (count != '0);
    assign rd_word  = mem[rd_ptr];

    assign rx.credit_ret  = pop;                    // Freed slot goes straight back as a credit
    assign rx.credit_init = CREDIT_W'(FIFO_DEPTH);  // Every slot is a credit after reset

endmodule

// ==== design/uart_line_pkg.sv ====
package uart_line_pkg;

    // Frame format used when the top level is not told otherwise
    localparam int DEF_DATA_BITS = 8;  // Data bits per frame
    localparam int DEF_STOP_BITS = 2;  // Stop bits per frame

    // Oversampling ratio of the receiver
    // A bit is sixteen ticks long and is sampled on its eighth tick
    localparam int OVERSAMPLE = 16;

    // Receiver states
    // IDLE waits for the line to drop and is the only state with the tick stopped
    typedef enum logic [2:0] {
        IDLE    = 3'd0,  // Line idle, waiting for a start edge
        START   = 3'd1,  // Start bit, re-checked at mid-bit to reject glitches
        DATA    = 3'd2,  // Data bits, least significant first
        PARITY  = 3'd3,  // Even parity bit
        STOP    = 3'd4,  // One or two stop bits
        DELIVER = 3'd5   // One cycle to push the word or count an overrun
    } rx_state_t;

endpackage

// ==== design/uart_rx_frame.sv ====
`timescale 1ns/1ns

// Serial frame receiver
// Finds the start edge, samples each bit at mid-bit on the oversampling tick,
// checks parity, stop bits and break, and pushes one word per frame to the FIFO
// while credits last
module uart_rx_frame import uart_line_pkg::*, rx_data_pkg::*; #(
    parameter int DATA_BITS = DEF_DATA_BITS,
    parameter int STOP_BITS = DEF_STOP_BITS
) (
    input  logic            Clk,
    input  logic            Rst,
    input  logic            rx_in,  // Asynchronous serial line, idle high
    input  logic            tick,   // Oversampling tick from the divider
    output logic            run,    // Keeps the divider going while busy
    output logic            rts,    // Remote side may send the next frame
    rx_credit_if.sender     tx
);

    localparam int TW = $clog2(OVERSAMPLE);
    localparam int BW = $clog2(DATA_BITS);

    localparam logic [TW-1:0] MID_TICK  = TW'(OVERSAMPLE / 2 - 1);  // Eighth tick of a bit
    localparam logic [TW-1:0] LAST_TICK = TW'(OVERSAMPLE - 1);      // Sixteenth tick of a bit

    rx_state_t state;

    logic [1:0]          rx_sync;       // Two-stage synchronizer, line idles high
    logic                rx_s;          // Synchronized line
    logic [TW-1:0]       tick_cnt;      // Tick position within the current bit
    logic [BW-1:0]       bit_cnt;       // Data or stop bit index
    logic [DATA_BITS-1:0] shreg;        // Data shifted in LSB first
    logic                parity_acc;    // Running XOR of the data bits
    logic                all_low;       // Every sample so far was low
    logic                parity_err_q;
    logic                frame_err_q;
    logic                ovr_sticky;    // A word was dropped and not yet reported
    logic [CREDIT_W-1:0] credits;       // Free FIFO slots as the receiver sees them
    logic                credits_ok;    // Credit count has been loaded after reset
    logic                have_credit;
    logic                mid_tick;
    logic                last_tick;

    assign rx_s      = rx_sync[1];
    assign mid_tick  = tick && (tick_cnt == MID_TICK);
    assign last_tick = tick && (tick_cnt == LAST_TICK);

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx_in};
        end
    end

    // Frame FSM
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state        <= IDLE;
            tick_cnt     <= '0;
            bit_cnt      <= '0;
            parity_acc   <= 1'b0;
            all_low      <= 1'b0;
            parity_err_q <= 1'b0;
            frame_err_q  <= 1'b0;
            ovr_sticky   <= 1'b0;
        end else begin
            if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;  // Wraps to zero at the end of each bit
            end
            case (state)
                IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    if (!rx_s) begin  // Possible start edge
                        state        <= START;
                        parity_acc   <= 1'b0;
                        all_low      <= 1'b1;
                        parity_err_q <= 1'b0;
                        frame_err_q  <= 1'b0;
                    end
                end
                START: begin
                    if (mid_tick && rx_s) begin
                        state <= IDLE;  // Line went back high so it was only a glitch
                    end else if (last_tick) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (mid_tick) begin
                        parity_acc <= parity_acc ^ rx_s;
                        all_low    <= all_low & ~rx_s;
                    end
                    if (last_tick) begin
                        if (bit_cnt == BW'(DATA_BITS - 1)) begin
                            bit_cnt <= '0;
                            state   <= PARITY;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                PARITY: begin
                    if (mid_tick) begin
                        parity_err_q <= rx_s ^ parity_acc;  // Even parity, so the XOR must match
                        all_low      <= all_low & ~rx_s;
                    end
                    if (last_tick) begin
                        state <= STOP;
                    end
                end
                STOP: begin
                    if (mid_tick) begin
                        if (!rx_s) begin
                            frame_err_q <= 1'b1;  // Any low stop bit is a framing error
                        end
                        all_low <= all_low & ~rx_s;
                        if (bit_cnt == BW'(STOP_BITS - 1)) begin
                            state <= DELIVER;  // No need to wait out the last stop bit
                        end
                    end
                    if (last_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                DELIVER: begin
                    state      <= IDLE;
                    ovr_sticky <= !have_credit;  // Cleared once reported, set when dropped
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Data shift register
    always_ff @(posedge Clk) begin
        if (state == DATA && mid_tick) begin
            shreg <= {rx_s, shreg[DATA_BITS-1:1]};  // LSB arrives first and ends up at bit 0
        end
    end

    // Credit counter
    // The count is loaded from the FIFO in the first cycle after reset
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            credits    <= '0;
            credits_ok <= 1'b0;
        end else if (!credits_ok) begin
            credits    <= tx.credit_init;
            credits_ok <= 1'b1;
        end else begin
            case ({tx.push, tx.credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // Both or neither leave it unchanged
            endcase
        end
    end

    assign have_credit = (credits != '0);

    assign tx.push = (state == DELIVER) && have_credit;  // Dropped otherwise
    assign tx.word = '{
        err: '{
            overrun:    ovr_sticky,
            break_err:  all_low,
            frame_err:  frame_err_q,
            parity_err: parity_err_q
        },
        data: MAX_DATA_BITS'(shreg)  // Right-aligned, zero above
    };

    assign run = (state != IDLE);                 // Tick runs for the whole frame
    assign rts = (state == IDLE) && have_credit;  // Ready only when idle and with room

endmodule

// ==== design/uart_rx_top.sv ====
`timescale 1ns/1ns

// UART receive path
// Serial line in, words with error flags out through a FIFO, with RTS toward the sender
module uart_rx_top import uart_line_pkg::*, rx_data_pkg::*; #(
    parameter int DATA_BITS     = DEF_DATA_BITS,
    parameter int STOP_BITS     = DEF_STOP_BITS,
    parameter int CLKS_PER_TICK = 4,
    parameter int FIFO_DEPTH    = 8
) (
    input  logic     Clk,
    input  logic     Rst,
    input  logic     rx_in,     // Serial data from the remote transmitter
    input  logic     rd_en,     // Host read strobe
    output logic     rts,       // Ready to send toward the remote transmitter
    output logic     rd_valid,  // A word is waiting for the host
    output rx_word_t rd_word    // Oldest waiting word
);

    logic tick;  // Oversampling tick
    logic run;   // Receiver busy, keeps the divider running

    rx_credit_if link ();  // Words one way, credits the other

    oversample_tick_gen #(
        .CLKS_PER_TICK (CLKS_PER_TICK)
    ) i_tick_gen (
        .Clk  (Clk),
        .Rst  (Rst),
        .run  (run),
        .tick (tick)
    );

    uart_rx_frame #(
        .DATA_BITS (DATA_BITS),
        .STOP_BITS (STOP_BITS)
    ) i_rx_frame (
        .Clk   (Clk),
        .Rst   (Rst),
        .rx_in (rx_in),
        .tick  (tick),
        .run   (run),
        .rts   (rts),
        .tx    (link.sender)
    );

    rx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_rx_fifo (
        .Clk      (Clk),
        .Rst      (Rst),
        .rx       (link.receiver),
        .rd_en    (rd_en),
        .rd_valid (rd_valid),
        .rd_word  (rd_word)
    );

endmodule

// ==== filelist.f ====
design/uart_line_pkg.sv
design/rx_data_pkg.sv
design/rx_credit_if.sv
design/oversample_tick_gen.sv
design/uart_rx_frame.sv
design/rx_fifo.sv
design/uart_rx_top.sv
verification/uart_rx_props.sv
verification/uart_rx_tb.sv

// ==== verification/uart_rx_props.sv ====
`timescale 1ns/1ns

// Protocol checks on the frame receiver, bound to every instance
module uart_rx_props import uart_line_pkg::*, rx_data_pkg::*; (
    input logic                Clk,
    input logic                Rst,
    input rx_state_t           state,
    input logic                push,
    input logic                credit_ret,
    input logic [CREDIT_W-1:0] credit_init,
    input logic                rts,
    input logic                run,
    input logic                tick
);

    logic [CREDIT_W-1:0] in_fifo;  // Words pushed and not yet handed back

    // FIFO occupancy counted from the link traffic alone, apart from the receiver's own count
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            in_fifo <= '0;
        end else begin
            in_fifo <= in_fifo + CREDIT_W'(push) - CREDIT_W'(credit_ret);
        end
    end

    // Every pushed word must have a free FIFO slot behind it
    push_needs_room: assert property (@(posedge Clk) disable iff (Rst)
        push |-> in_fifo < credit_init)
        else $error("push while every FIFO slot was taken");

    // The remote side may only send while the receiver waits for a start edge and has room
    rts_needs_room: assert property (@(posedge Clk) disable iff (Rst)
        rts |-> (state == IDLE) && (in_fifo < credit_init))
        else $error("rts high outside IDLE or with a full FIFO");

    // Ticks come only while run is high or in the cycle right after it falls
    tick_within_run: assert property (@(posedge Clk) disable iff (Rst)
        tick |-> run || $past(run))
        else $error("oversampling tick while the receiver was idle");

endmodule

bind uart_rx_frame uart_rx_props i_props (
    .Clk         (Clk),
    .Rst         (Rst),
    .state       (state),
    .push        (tx.push),
    .credit_ret  (tx.credit_ret),
    .credit_init (tx.credit_init),
    .rts         (rts),
    .run         (run),
    .tick        (tick)
);

// ==== verification/uart_rx_tb.sv ====
`timescale 1ns/1ns

// Table-driven testbench for the UART receive path
// A serial driver sends frames, a reader drains the FIFO and compares against a model queue
module uart_rx_tb import uart_line_pkg::*, rx_data_pkg::*;;

    localparam int DATA_BITS     = DEF_DATA_BITS;
    localparam int STOP_BITS     = 2;
    localparam int CLKS_PER_TICK = 4;
    localparam int FIFO_DEPTH    = 4;
    localparam int CLK_PERIOD    = 10;
    localparam int BIT_CLKS      = CLKS_PER_TICK * OVERSAMPLE;   // Clk cycles per serial bit
    localparam int FRAME_BITS    = 1 + DATA_BITS + 1 + STOP_BITS;
    localparam int MARGIN        = 50 * BIT_CLKS * CLK_PERIOD;   // Slack for glitches and drain

    // One frame to send and how to corrupt it
    typedef struct {
        logic [MAX_DATA_BITS-1:0] data;
        bit                       flip_parity;  // Send odd parity instead of even
        bit                       zero_stop;    // Send every stop bit low
        bit                       brk;          // Hold the line low for the whole frame
        bit                       hold_reads;   // Host stops reading during this frame
        bit                       glitch;       // Short low pulse on the idle line first
    } frame_row_t;

    logic     Clk;
    logic     Rst;
    logic     rx_in;
    logic     rd_en;
    logic     rts;
    logic     rd_valid;
    rx_word_t rd_word;

    frame_row_t rows[$];
    rx_word_t   exp_q[$];     // Words the FIFO should hand out, oldest first
    bit         ovr_pending;  // Model of the receiver's sticky overrun flag
    bit         hold;         // Reader paused
    integer     seed = 32'h938dbd73;
    int         data_errs  = 0;
    int         flag_errs  = 0;
    int         rts_errs   = 0;
    int         other_errs = 0;

    uart_rx_top #(
        .DATA_BITS     (DATA_BITS),
        .STOP_BITS     (STOP_BITS),
        .CLKS_PER_TICK (CLKS_PER_TICK),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) i_dut (
        .Clk      (Clk),
        .Rst      (Rst),
        .rx_in    (rx_in),
        .rd_en    (rd_en),
        .rts      (rts),
        .rd_valid (rd_valid),
        .rd_word  (rd_word)
    );

    initial Clk = 1'b0;
    always #(CLK_PERIOD / 2) Clk = ~Clk;

    task automatic check_data(input logic [MAX_DATA_BITS-1:0] got,
                              input logic [MAX_DATA_BITS-1:0] exp);
        if (got !== exp) begin
            data_errs++;
            $display("** Error: rd_word.data = 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_err(input rx_err_t got, input rx_err_t exp);
        if (got !== exp) begin
            flag_errs++;
            $display("** Error: rd_word.err = 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_rts(input logic got, input logic exp);
        if (got !== exp) begin
            rts_errs++;
            $display("** Error: rts = 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic add_row(input logic [MAX_DATA_BITS-1:0] data, input bit flip, input bit zstop,
                           input bit brk, input bit hold_rd, input bit glitch);
        rows.push_back('{data, flip, zstop, brk, hold_rd, glitch});
    endtask

    // Line levels that a row puts on the wire
    function automatic logic [MAX_DATA_BITS-1:0] sent_data(input frame_row_t row);
        return row.brk ? '0 : row.data;
    endfunction

    function automatic logic sent_parity(input frame_row_t row);
        return row.brk ? 1'b0 : ((^sent_data(row)) ^ row.flip_parity);  // Even parity unless flipped
    endfunction

    function automatic logic sent_stop(input frame_row_t row);
        return !(row.brk || row.zero_stop);
    endfunction

    // Word the host should see, from the frame rules
    function automatic rx_word_t expected_word(input frame_row_t row, input bit ovr);
        rx_word_t w;
        w.data           = sent_data(row);
        w.err.overrun    = ovr;
        w.err.parity_err = sent_parity(row) ^ (^sent_data(row));
        w.err.frame_err  = !sent_stop(row);
        w.err.break_err  = (sent_data(row) == '0) && !sent_parity(row) && !sent_stop(row);
        return w;
    endfunction

    // Each bit lasts BIT_CLKS cycles, and the task returns 1 ns after a rising edge
    task automatic send_bit(input logic b);
        rx_in = b;
        repeat (BIT_CLKS) @(posedge Clk);
        #1;
    endtask

    task automatic send_frame(input frame_row_t row);
        logic [MAX_DATA_BITS-1:0] bits;
        int i;
        bits = sent_data(row);
        send_bit(1'b0);  // Start bit
        for (i = 0; i < DATA_BITS; i++) begin
            send_bit(bits[i]);  // LSB first
        end
        send_bit(sent_parity(row));
        for (i = 0; i < STOP_BITS; i++) begin
            send_bit(sent_stop(row));
        end
        rx_in = 1'b1;  // Back to idle
    endtask

    // Low pulse of a quarter bit, then a full bit of idle line
    task automatic send_glitch();
        rx_in = 1'b0;
        repeat (BIT_CLKS / 4) @(posedge Clk);
        #1;
        rx_in = 1'b1;
        repeat (BIT_CLKS) @(posedge Clk);
        #1;
    endtask

    task automatic wait_rts();
        while (rts !== 1'b1) begin
            @(posedge Clk);
            #1;
        end
    endtask

    initial begin : main
        frame_row_t row;
        int n;
        Rst         = 1'b1;
        rx_in       = 1'b1;
        hold        = 1'b0;
        ovr_pending = 1'b0;
        add_row(8'h55, 0, 0, 0, 0, 0);  // Clean frames
        add_row(8'hA3, 0, 0, 0, 0, 0);
        add_row(8'h00, 0, 0, 0, 0, 0);
        add_row(8'hFF, 0, 0, 0, 0, 0);
        for (n = 0; n < 3; n++) begin
            add_row(MAX_DATA_BITS'($random(seed)), 0, 0, 0, 0, 0);
        end
        add_row(8'h3C, 1, 0, 0, 0, 0);  // Parity flipped
        add_row(8'h81, 0, 1, 0, 0, 0);  // Low stop bits
        add_row(8'h00, 0, 0, 1, 0, 0);  // Break
        add_row(8'h5A, 0, 0, 0, 0, 0);
        add_row(8'h11, 0, 0, 0, 1, 0);  // Four words fill the FIFO with reads held
        add_row(8'h22, 0, 0, 0, 1, 0);
        add_row(8'h33, 0, 0, 0, 1, 0);
        add_row(8'h44, 0, 0, 0, 1, 0);
        add_row(8'h55, 0, 0, 0, 1, 0);  // No room left, this one is lost
        add_row(8'h66, 0, 0, 0, 0, 0);  // Carries the overrun flag
        add_row(8'h99, 0, 0, 0, 0, 1);  // Glitch on the idle line first
        add_row(MAX_DATA_BITS'($random(seed)), 0, 0, 0, 0, 0);
        repeat (2) @(posedge Clk);
        #1;
        Rst = 1'b0;
        for (n = 0; n < rows.size(); n++) begin
            row  = rows[n];
            hold = row.hold_reads;
            if (row.glitch) begin
                wait_rts();
                send_glitch();
            end
            if (!row.hold_reads) begin
                wait_rts();  // Flow control toward the sender
            end
            if (exp_q.size() >= FIFO_DEPTH) begin
                ovr_pending = 1'b1;  // Receiver will drop this word
            end else begin
                exp_q.push_back(expected_word(row, ovr_pending));
                ovr_pending = 1'b0;
            end
            send_frame(row);
            if (row.hold_reads) begin
                check_rts(rts, exp_q.size() < FIFO_DEPTH);  // Falls once the FIFO is full
            end
        end
        while (exp_q.size() != 0) begin
            @(posedge Clk);
        end
        repeat (4 * BIT_CLKS) @(posedge Clk);  // Catch any stray word
        $display("Errors: data %0d, flags %0d, rts %0d, other %0d",
                 data_errs, flag_errs, rts_errs, other_errs);
        if (data_errs + flag_errs + rts_errs + other_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Host reader that pops one word per cycle while reads are not held
    initial begin : reader
        rx_word_t exp_w;
        rd_en = 1'b0;
        forever begin
            @(posedge Clk);
            #1;
            rd_en = 1'b0;
            if (!Rst && rd_valid && !hold) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("Unexpected word 0x%h came out of the FIFO at %0t", rd_word, $time);
                end else begin
                    exp_w = exp_q.pop_front();
                    check_data(rd_word.data, exp_w.data);
                    check_err(rd_word.err, exp_w.err);
                end
                rd_en = 1'b1;
            end
        end
    end

    // Twice the serial time of the whole table plus slack
    initial begin : watchdog
        @(negedge Rst);
        #(rows.size() * FRAME_BITS * BIT_CLKS * CLK_PERIOD * 2 + MARGIN);
        $display("Watchdog expired with %0d expected words never read", exp_q.size());
        $display("Simulation failed");
        $finish;
    end

endmodule
